//--- vslide.f
+incdir+include
logic/vslide_pkg.sv
logic/vslide_ifs.sv
logic/vslide_decode.sv
logic/vslide_lane.sv
logic/vslide_collect.sv
logic/vslide_unit.sv
tests/vslide_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the vslide testbench with Verilator
set -o pipefail
cd "$(dirname "$0")" || exit 1
mkdir -p build
verilator --binary --timing --assert -f vslide.f --top-module vslide_tb -Mdir build/obj_dir \
    && build/obj_dir/Vvslide_tb 2>&1 | tee build/sim.log \
    || { echo "build or simulation did not complete"; exit 1; }
grep -q "Regression failed" build/sim.log && exit 1 || exit 0

//--- tests/vslide_tb.sv
////////////////////////////////////////////////////////////////////////////
// directed testbench of the vector slide unit
// byte-rule reference model, LFSR stimulus, in-order scoreboard
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "vslide_params.svh"

module vslide_tb import vslide_pkg::*; ();

    localparam int VBYTES     = `VSLIDE_VREG_BYTES;
    localparam int LAT_CYCLES = 3;
    localparam int MAX_WAIT   = 400;     // cycles per batch

    typedef struct {
        instr_id_t id;
        vsew_e     sew;
        sld_dir_e  dir;
        logic      s1;
        vl_t       vl;
        xval_t     xval;
        vreg_t     vs2;
        vreg_t     vdold;
        vreg_t     exp;
        int        acc;    // cycle of acceptance
    } op_t;

    logic      clk_i;
    logic      rst_i;
    logic      in_valid_i;
    logic      in_ready_o;
    instr_id_t in_id_i;
    vsew_e     in_vsew_i;
    sld_dir_e  in_dir_i;
    logic      in_slide1_i;
    vl_t       in_vl_i;
    xval_t     in_xval_i;
    vreg_t     in_vs2_i;
    vreg_t     in_vd_old_i;
    logic      out_valid_o;
    logic      out_ready_i;
    instr_id_t out_id_o;
    vreg_t     out_vd_o;

    op_t         op_q[$];     // not yet accepted
    op_t         out_q[$];    // accepted, result pending
    logic [31:0] lfsr_q;
    int          cyc;
    int          err_cnt;
    int          timeout_cnt;
    int          results;
    instr_id_t   next_id;
    logic        stuck;

    vslide_unit i_dut (
        .clk_i       ( clk_i       ),
        .rst_i       ( rst_i       ),
        .in_valid_i  ( in_valid_i  ),
        .in_ready_o  ( in_ready_o  ),
        .in_id_i     ( in_id_i     ),
        .in_vsew_i   ( in_vsew_i   ),
        .in_dir_i    ( in_dir_i    ),
        .in_slide1_i ( in_slide1_i ),
        .in_vl_i     ( in_vl_i     ),
        .in_xval_i   ( in_xval_i   ),
        .in_vs2_i    ( in_vs2_i    ),
        .in_vd_old_i ( in_vd_old_i ),
        .out_valid_o ( out_valid_o ),
        .out_ready_i ( out_ready_i ),
        .out_id_o    ( out_id_o    ),
        .out_vd_o    ( out_vd_o    )
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus helpers and reference model

    function automatic logic next_bit();
        logic b;
        b      = lfsr_q[0];
        lfsr_q = lfsr_q >> 1;
        if (b) begin
            lfsr_q = lfsr_q ^ 32'h8020_0003;   // taps 32 22 2 1
        end
        return b;
    endfunction

    function automatic logic [127:0] rand_bits(input int n);
        logic [127:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[i] = next_bit();
        end
        return v;
    endfunction

    function automatic vreg_t ramp(input logic [7:0] base);
        vreg_t r;
        for (int i = 0; i < VBYTES; i++) begin
            r[8*i +: 8] = base + 8'(i);
        end
        return r;
    endfunction

    // element view of the slide, byte k of element e
    function automatic vreg_t ref_slide(input op_t o);
        int    eb;
        int    nelem;
        int    off;
        int    e;
        int    k;
        vreg_t r;
        eb    = 1 << int'(o.sew);
        nelem = VBYTES / eb;
        off   = o.s1 ? 1 : ((o.xval > 32'd16) ? 16 : int'(o.xval));
        for (int b = 0; b < VBYTES; b++) begin
            e = b / eb;
            k = b % eb;
            if (b >= int'(o.vl) * eb) begin
                r[8*b +: 8] = o.vdold[8*b +: 8];
            end else if (o.s1 && o.dir == SLD_UP && e == 0) begin
                r[8*b +: 8] = o.xval[8*k +: 8];
            end else if (o.s1 && o.dir == SLD_DOWN && e == int'(o.vl) - 1) begin
                r[8*b +: 8] = o.xval[8*k +: 8];
            end else if (o.dir == SLD_UP && e >= off) begin
                r[8*b +: 8] = o.vs2[8*((e - off) * eb + k) +: 8];
            end else if (o.dir == SLD_UP) begin
                r[8*b +: 8] = o.vdold[8*b +: 8];
            end else if (e + off < nelem) begin
                r[8*b +: 8] = o.vs2[8*((e + off) * eb + k) +: 8];
            end else begin
                r[8*b +: 8] = 8'h00;
            end
        end
        return r;
    endfunction

    task automatic issue_op(input vsew_e sew, input sld_dir_e dir, input logic s1,
                            input vl_t vl, input xval_t xval, input vreg_t vs2,
                            input vreg_t vdold);
        op_t o;
        o.id    = next_id;
        o.sew   = sew;
        o.dir   = dir;
        o.s1    = s1;
        o.vl    = vl;
        o.xval  = xval;
        o.vs2   = vs2;
        o.vdold = vdold;
        o.acc   = 0;
        o.exp   = ref_slide(o);
        op_q.push_back(o);
        next_id = next_id + 3'd1;
    endtask

    task automatic issue_random_op();
        int    w;
        int    n;
        logic  s1;
        xval_t x;
        w  = int'(rand_bits(2)) % 3;
        n  = VBYTES >> w;
        s1 = next_bit();
        if (s1) begin
            x = xval_t'(rand_bits(32));
        end else begin
            x = next_bit() ? xval_t'(rand_bits(3)) : xval_t'(rand_bits(32));
        end
        issue_op(vsew_e'(w), sld_dir_e'(next_bit()), s1, vl_t'(int'(rand_bits(5)) % (n + 1)),
                 x, vreg_t'(rand_bits(128)), vreg_t'(rand_bits(128)));
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // drive queued ops and score results until both queues drain

    task automatic run_ops(input logic rand_ready, input logic check_lat);
        op_t cur;
        int  waited;
        waited = 0;
        while ((op_q.size() > 0 || out_q.size() > 0) && !stuck) begin
            @(negedge clk_i);
            cyc++;
            waited++;
            out_ready_i = rand_ready ? next_bit() : 1'b1;
            in_valid_i  = op_q.size() > 0;
            if (op_q.size() > 0) begin
                cur         = op_q[0];
                in_id_i     = cur.id;
                in_vsew_i   = cur.sew;
                in_dir_i    = cur.dir;
                in_slide1_i = cur.s1;
                in_vl_i     = cur.vl;
                in_xval_i   = cur.xval;
                in_vs2_i    = cur.vs2;
                in_vd_old_i = cur.vdold;
            end
            #1;
            if (check_lat && in_valid_i) begin
                assert (in_ready_o) else begin
                    $display("ERROR: in_ready_o 0x%0h expected 0x1 while streaming", in_ready_o);
                    err_cnt++;
                end
            end
            if (in_valid_i && in_ready_o) begin
                cur     = op_q.pop_front();
                cur.acc = cyc;
                out_q.push_back(cur);
            end
            if (out_valid_o && out_ready_i) begin
                assert (out_q.size() > 0) else begin
                    $display("a result arrived with no instruction pending");
                    err_cnt++;
                end
                if (out_q.size() > 0) begin
                    cur = out_q.pop_front();
                    results++;
                    assert (out_id_o == cur.id) else begin
                        $display("ERROR: out_id_o 0x%0h expected 0x%0h", out_id_o, cur.id);
                        err_cnt++;
                    end
                    assert (out_vd_o == cur.exp) else begin
                        $display("ERROR: out_vd_o 0x%032h expected 0x%032h (id 0x%0h)",
                                 out_vd_o, cur.exp, cur.id);
                        err_cnt++;
                    end
                    if (check_lat) begin
                        assert (cyc - cur.acc == LAT_CYCLES) else begin
                            $display("instruction %0d took %0d cycles instead of %0d",
                                     cur.id, cyc - cur.acc, LAT_CYCLES);
                            err_cnt++;
                        end
                    end
                end
            end
            if (waited > MAX_WAIT) begin
                $display("timeout with %0d results still pending after %0d cycles",
                         op_q.size() + out_q.size(), waited);
                timeout_cnt++;
                stuck = 1'b1;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // tests

    task automatic test_reset();
        assert (out_valid_o == 1'b0) else begin
            $display("ERROR: out_valid_o 0x%0h expected 0x0 after reset", out_valid_o);
            err_cnt++;
        end
        assert (in_ready_o == 1'b1) else begin
            $display("ERROR: in_ready_o 0x%0h expected 0x1 after reset", in_ready_o);
            err_cnt++;
        end
    endtask

    task automatic test_slide(input sld_dir_e dir);
        int offs[5];
        int n;
        int vl;
        for (int w = 0; w < 3; w++) begin
            n = VBYTES >> w;
            for (int v = 0; v < 2; v++) begin
                vl   = (v == 0) ? n : n - n / 4 - 1;     // full and partial
                offs = '{0, 1, 3, vl, 20};
                for (int o = 0; o < 5; o++) begin
                    issue_op(vsew_e'(w), dir, 1'b0, vl_t'(vl), xval_t'(offs[o]),
                             ramp(8'h10), ramp(8'hA0));
                end
            end
        end
        run_ops(1'b0, 1'b0);
    endtask

    task automatic test_slide1();
        int n;
        for (int w = 0; w < 3; w++) begin
            n = VBYTES >> w;
            for (int d = 0; d < 2; d++) begin
                issue_op(vsew_e'(w), sld_dir_e'(d), 1'b1, vl_t'(n), 32'h5A6B_7C8D,
                         ramp(8'h30), ramp(8'hC0));
                issue_op(vsew_e'(w), sld_dir_e'(d), 1'b1, vl_t'(n / 2 + 1), 32'h5A6B_7C8D,
                         ramp(8'h30), ramp(8'hC0));
                issue_op(vsew_e'(w), sld_dir_e'(d), 1'b1, vl_t'(0), 32'h5A6B_7C8D,
                         ramp(8'h30), ramp(8'hC0));
            end
        end
        run_ops(1'b0, 1'b0);
    endtask

    task automatic test_latency();
        issue_op(VSEW_16, SLD_UP, 1'b0, vl_t'(8), 32'd2, ramp(8'h50), ramp(8'hE0));
        run_ops(1'b0, 1'b1);
        repeat (8) issue_random_op();     // back to back burst
        run_ops(1'b0, 1'b1);
    endtask

    task automatic test_backpressure();
        repeat (40) issue_random_op();
        run_ops(1'b1, 1'b0);
        repeat (6) begin
            @(negedge clk_i);
            out_ready_i = 1'b1;
            #1;
            assert (!out_valid_o) else begin
                $display("an extra result appeared after all results were taken");
                err_cnt++;
            end
        end
    endtask

    initial begin
        rst_i       = 1'b1;
        in_valid_i  = 1'b0;
        in_id_i     = '0;
        in_vsew_i   = VSEW_8;
        in_dir_i    = SLD_UP;
        in_slide1_i = 1'b0;
        in_vl_i     = '0;
        in_xval_i   = '0;
        in_vs2_i    = '0;
        in_vd_old_i = '0;
        out_ready_i = 1'b1;
        lfsr_q      = 32'd38;
        cyc         = 0;
        err_cnt     = 0;
        timeout_cnt = 0;
        results     = 0;
        next_id     = '0;
        stuck       = 1'b0;
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;
        #1;
        test_reset();
        test_slide(SLD_UP);
        test_slide(SLD_DOWN);
        test_slide1();
        test_latency();
        test_backpressure();
        $display("results %0d, errors %0d, timeouts %0d", results, err_cnt, timeout_cnt);
        if (err_cnt == 0 && timeout_cnt == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- logic/vslide_unit.sv
////////////////////////////////////////////////////////////////////////////
// vector slide unit top, decode -> lanes -> collector
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "vslide_params.svh"

module vslide_unit import vslide_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_i,

    input  logic       in_valid_i,
    output logic       in_ready_o,
    input  instr_id_t  in_id_i,
    input  vsew_e      in_vsew_i,
    input  sld_dir_e   in_dir_i,
    input  logic       in_slide1_i,
    input  vl_t        in_vl_i,
    input  xval_t      in_xval_i,
    input  vreg_t      in_vs2_i,
    input  vreg_t      in_vd_old_i,

    output logic       out_valid_o,
    input  logic       out_ready_i,
    output instr_id_t  out_id_o,
    output vreg_t      out_vd_o
);

    slide_op_if  op_if ();
    slide_res_if res_if [`VSLIDE_LANE_CNT] ();

    vslide_decode i_decode (
        .clk_i       ( clk_i       ),
        .rst_i       ( rst_i       ),
        .in_valid_i  ( in_valid_i  ),
        .in_ready_o  ( in_ready_o  ),
        .in_id_i     ( in_id_i     ),
        .in_vsew_i   ( in_vsew_i   ),
        .in_dir_i    ( in_dir_i    ),
        .in_slide1_i ( in_slide1_i ),
        .in_vl_i     ( in_vl_i     ),
        .in_xval_i   ( in_xval_i   ),
        .in_vs2_i    ( in_vs2_i    ),
        .in_vd_old_i ( in_vd_old_i ),
        .op          ( op_if       )
    );

    // op broadcast to every lane
    for (genvar g = 0; g < `VSLIDE_LANE_CNT; g++) begin : g_lane
        vslide_lane #(
            .LANE_IDX ( g )
        ) i_lane (
            .clk_i ( clk_i     ),
            .rst_i ( rst_i     ),
            .op    ( op_if     ),
            .res   ( res_if[g] )
        );
    end

    vslide_collect i_collect (
        .clk_i       ( clk_i       ),
        .rst_i       ( rst_i       ),
        .res         ( res_if      ),
        .out_valid_o ( out_valid_o ),
        .out_ready_i ( out_ready_i ),
        .out_id_o    ( out_id_o    ),
        .out_vd_o    ( out_vd_o    )
    );

endmodule

`default_nettype wire

//--- logic/vslide_collect.sv
////////////////////////////////////////////////////////////////////////////
// output slot, joins the lane chunks into one register
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "vslide_params.svh"

module vslide_collect import vslide_pkg::*; (
    input  logic          clk_i,
    input  logic          rst_i,

    slide_res_if.collect  res [`VSLIDE_LANE_CNT],

    output logic          out_valid_o,
    input  logic          out_ready_i,
    output instr_id_t     out_id_o,
    output vreg_t         out_vd_o
);

    localparam int unsigned LANES = `VSLIDE_LANE_CNT;

    logic [LANES-1:0]      lane_valid;
    instr_id_t [LANES-1:0] lane_id;
    vreg_t                 joined;
    logic                  slot_ready;
    logic                  take;
    logic                  ids_match;

    assign slot_ready = ~out_valid_o | out_ready_i;

    // lane 0 in the low bytes
    for (genvar i = 0; i < LANES; i++) begin : g_lane
        assign lane_valid[i]                             = res[i].valid;
        assign lane_id[i]                                = res[i].id;
        assign joined[`VSLIDE_LANE_W*i +: `VSLIDE_LANE_W] = res[i].data;
        assign res[i].ready                              = slot_ready;
    end

    assign take = lane_valid[0] & slot_ready;

    always_comb begin
        ids_match = 1'b1;
        for (int i = 1; i < LANES; i++) begin
            if (lane_id[i] != lane_id[0]) begin
                ids_match = 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            out_valid_o <= 1'b0;
        end else if (take) begin
            out_valid_o <= 1'b1;
        end else if (out_ready_i) begin
            out_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (take) begin
            out_vd_o <= joined;
            out_id_o <= lane_id[0];
        end
    end

    // lanes share one op and one ready, so they never drift apart
    a_lanes_agree: assert property (@(posedge clk_i) disable iff (rst_i)
        (lane_valid == {LANES{lane_valid[0]}}) && (!lane_valid[0] || ids_match))
        else $error("vslide_collect: lane_valid 0x%0h lane_id 0x%0h", lane_valid, lane_id);

endmodule

`default_nettype wire

//--- logic/vslide_lane.sv
////////////////////////////////////////////////////////////////////////////
// one 32-bit lane, builds four result bytes of the slide
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "vslide_params.svh"

module vslide_lane import vslide_pkg::*; #(
    parameter int unsigned LANE_IDX = 0
) (
    input  logic       clk_i,
    input  logic       rst_i,

    slide_op_if.lane   op,
    slide_res_if.lane  res
);

    localparam int unsigned LANE_BYTES = `VSLIDE_LANE_W / 8;
    localparam int unsigned BASE       = LANE_IDX * LANE_BYTES;   // first byte owned

    logic                       valid_q;
    logic                       take;
    logic                       slide1_up;
    logic                       slide1_dn;
    byte_cnt_t                  last_start;   // first byte of element vl-1
    logic [1:0]                 sc_mask;
    logic [LANE_BYTES-1:0][7:0] byte_nxt;

    assign slide1_up  = op.slide1 & (op.dir == SLD_UP);
    assign slide1_dn  = op.slide1 & (op.dir == SLD_DOWN);
    assign last_start = op.vl_bytes - op.elem_bytes;
    assign sc_mask    = op.elem_bytes[1:0] - 2'd1;    // 1,2,4 bytes -> 0,1,3

    ////////////////////////////////////////////////////////////////////////////
    // byte select

    for (genvar k = 0; k < LANE_BYTES; k++) begin : g_byte
        localparam byte_cnt_t B = byte_cnt_t'(BASE + k);

        logic [5:0] up_idx;
        logic [5:0] dn_idx;
        logic [1:0] sc_idx;
        logic [7:0] sel;

        assign up_idx = {1'b0, B} - {1'b0, op.byte_off};
        assign dn_idx = {1'b0, B} + {1'b0, op.byte_off};
        assign sc_idx = B[1:0] & sc_mask;   // byte position inside its element

        always_comb begin
            if (B >= op.vl_bytes) begin
                sel = op.vd_old[8*B +: 8];                      // tail undisturbed
            end else if (slide1_up && (B < op.elem_bytes)) begin
                sel = op.xval[8*sc_idx +: 8];
            end else if (slide1_dn && (B >= last_start)) begin
                sel = op.xval[8*sc_idx +: 8];
            end else if (op.dir == SLD_UP) begin
                if (B >= op.byte_off) begin
                    sel = op.vs2[8*up_idx[3:0] +: 8];
                end else begin
                    sel = op.vd_old[8*B +: 8];                  // below offset keeps vd
                end
            end else begin
                if (dn_idx < 6'(`VSLIDE_VREG_BYTES)) begin
                    sel = op.vs2[8*dn_idx[3:0] +: 8];
                end else begin
                    sel = 8'h00;                                // past the register end
                end
            end
        end

        assign byte_nxt[k] = sel;
    end

    ////////////////////////////////////////////////////////////////////////////
    // output slot

    assign op.ready[LANE_IDX] = ~valid_q | res.ready;
    assign take               = op.valid & (&op.ready);   // all lanes move in step

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= 1'b0;
        end else if (take) begin
            valid_q <= 1'b1;
        end else if (res.ready) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (take) begin
            res.data <= byte_nxt;
            res.id   <= op.id;
        end
    end

    assign res.valid = valid_q;

endmodule

`default_nettype wire

//--- logic/vslide_decode.sv
////////////////////////////////////////////////////////////////////////////
// input register stage of the slide unit
// element offset and vl converted to byte counts
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "vslide_params.svh"

module vslide_decode import vslide_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_i,

    input  logic       in_valid_i,
    output logic       in_ready_o,
    input  instr_id_t  in_id_i,
    input  vsew_e      in_vsew_i,
    input  sld_dir_e   in_dir_i,
    input  logic       in_slide1_i,
    input  vl_t        in_vl_i,
    input  xval_t      in_xval_i,
    input  vreg_t      in_vs2_i,
    input  vreg_t      in_vd_old_i,

    slide_op_if.decode op
);

    localparam byte_cnt_t FULL_BYTES = byte_cnt_t'(`VSLIDE_VREG_BYTES);

    logic       valid_q;
    logic       accept;
    logic       handoff;
    logic [1:0] sew_shift;     // log2 of element bytes
    byte_cnt_t  elem_bytes;
    byte_cnt_t  byte_off;
    byte_cnt_t  vl_bytes;
    logic [6:0] off_full;
    logic [6:0] vl_full;

    // slot frees up when all lanes take the op together
    assign handoff    = valid_q & (&op.ready);
    assign in_ready_o = ~valid_q | (&op.ready);
    assign accept     = in_valid_i & in_ready_o;

    always_comb begin
        case (in_vsew_i)
            VSEW_16: sew_shift = 2'd1;
            VSEW_32: sew_shift = 2'd2;
            default: sew_shift = 2'd0;
        endcase
    end

    assign elem_bytes = byte_cnt_t'(1) << sew_shift;
    assign off_full   = {2'b00, in_xval_i[4:0]} << sew_shift;
    assign vl_full    = {2'b00, in_vl_i} << sew_shift;

    always_comb begin
        if (in_slide1_i) begin
            byte_off = elem_bytes;                  // slide by one element
        end else if ((|in_xval_i[31:5]) || (off_full > 7'(FULL_BYTES))) begin
            byte_off = FULL_BYTES;                  // slid out entirely
        end else begin
            byte_off = off_full[4:0];
        end
    end

    assign vl_bytes = (vl_full > 7'(FULL_BYTES)) ? FULL_BYTES : vl_full[4:0];

    ////////////////////////////////////////////////////////////////////////////
    // register slot

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= 1'b0;
        end else if (accept) begin
            valid_q <= 1'b1;
        end else if (handoff) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            op.id         <= in_id_i;
            op.dir        <= in_dir_i;
            op.slide1     <= in_slide1_i;
            op.byte_off   <= byte_off;
            op.vl_bytes   <= vl_bytes;
            op.elem_bytes <= elem_bytes;
            op.xval       <= in_xval_i;
            op.vs2        <= in_vs2_i;
            op.vd_old     <= in_vd_old_i;
        end
    end

    assign op.valid = valid_q;

    // 64-bit elements are outside this unit
    a_no_sew64: assert property (@(posedge clk_i) disable iff (rst_i)
        accept |-> in_vsew_i inside {VSEW_8, VSEW_16, VSEW_32})
        else $error("vslide_decode: unsupported vsew 0x%0h", in_vsew_i);

    // upstream keeps its request up until taken
    a_in_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        in_valid_i && !in_ready_o |=> in_valid_i && $stable(in_id_i))
        else $error("vslide_decode: in_valid_i dropped before accept");

endmodule

`default_nettype wire

//--- logic/vslide_ifs.sv
////////////////////////////////////////////////////////////////////////////
// slide_op_if   decode to lanes, one broadcast instance
// slide_res_if  lane to collector, one instance per lane
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "vslide_params.svh"

interface slide_op_if import vslide_pkg::*; ();

    logic                        valid;
    instr_id_t                   id;
    sld_dir_e                    dir;
    logic                        slide1;
    byte_cnt_t                   byte_off;    // slide amount in bytes
    byte_cnt_t                   vl_bytes;    // bytes below vl
    byte_cnt_t                   elem_bytes;
    xval_t                       xval;
    vreg_t                       vs2;
    vreg_t                       vd_old;
    logic [`VSLIDE_LANE_CNT-1:0] ready;       // one bit per lane

    modport decode (
        output valid, id, dir, slide1, byte_off, vl_bytes, elem_bytes,
        output xval, vs2, vd_old,
        input  ready
    );

    modport lane (
        input  valid, id, dir, slide1, byte_off, vl_bytes, elem_bytes,
        input  xval, vs2, vd_old,
        output ready
    );

endinterface

interface slide_res_if import vslide_pkg::*; ();

    logic       valid;
    instr_id_t  id;
    lane_data_t data;
    logic       ready;

    modport lane (
        output valid, id, data,
        input  ready
    );

    modport collect (
        input  valid, id, data,
        output ready
    );

endinterface

`default_nettype wire

//--- logic/vslide_pkg.sv
////////////////////////////////////////////////////////////////////////////
// shared vector, lane, count and id types
// element width and slide direction encodings
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "vslide_params.svh"

package vslide_pkg;

    // full register and one lane chunk
    typedef logic [`VSLIDE_VREG_W-1:0]   vreg_t;
    typedef logic [`VSLIDE_LANE_W-1:0]   lane_data_t;

    // 0 to 16 bytes, so one bit more than a byte index
    typedef logic [$clog2(`VSLIDE_VREG_BYTES):0] byte_cnt_t;

    typedef logic [`VSLIDE_ID_W-1:0]     instr_id_t;
    typedef logic [31:0]                 xval_t;     // scalar operand from rs1
    typedef logic [`VSLIDE_VL_W-1:0]     vl_t;

    ////////////////////////////////////////////////////////////////////////////
    // encodings

    // 2'b11 would be 64-bit elements, not supported here
    typedef enum logic [1:0] {
        VSEW_8  = 2'b00,
        VSEW_16 = 2'b01,
        VSEW_32 = 2'b10
    } vsew_e;

    typedef enum logic {
        SLD_UP   = 1'b0,
        SLD_DOWN = 1'b1
    } sld_dir_e;

endpackage

`default_nettype wire

//--- include/vslide_params.svh
////////////////////////////////////////////////////////////////////////////
// widths and counts of the vector slide unit
////////////////////////////////////////////////////////////////////////////

`ifndef VSLIDE_PARAMS_SVH
`define VSLIDE_PARAMS_SVH

// vector register geometry
`define VSLIDE_VREG_W       128
`define VSLIDE_VREG_BYTES   16

// lanes
`define VSLIDE_LANE_CNT     4
`define VSLIDE_LANE_W       32     // bits per lane, 4 bytes

// instruction id, wraps at 8
`define VSLIDE_ID_W         3

// vl in elements, at most 16
`define VSLIDE_VL_W         5

`endif
